// File: src/rst_cipher_defines.svh
`ifndef RST_CIPHER_DEFINES_SVH
`define RST_CIPHER_DEFINES_SVH

// character and key geometry
`define RST_CHAR_W    8
`define RST_KEY_LEN   12
`define RST_HALF_LEN  6

// symbol index covers 26 letters and 10 digits
`define RST_SYM_W     6

// ascii bounds of the accepted ranges
`define RST_UPPER_A   8'h41
`define RST_UPPER_Z   8'h5A
`define RST_LOWER_A   8'h61
`define RST_LOWER_Z   8'h7A
`define RST_DIGIT_0   8'h30
`define RST_DIGIT_9   8'h39

`endif

// File: src/rst_cipher_pkg.sv
`default_nettype none

`include "rst_cipher_defines.svh"

package rst_cipher_pkg;

  // one ascii character
  typedef logic [`RST_CHAR_W-1:0] char_t;

  // element 0 is the first key character
  typedef char_t [`RST_KEY_LEN-1:0] key_t;

  // row entry in the high byte, column entry in the low byte
  typedef logic [2*`RST_CHAR_W-1:0] ctxt_t;

  typedef logic [`RST_SYM_W-1:0] sym_idx_t;

  typedef enum logic {
    st_unkeyed = 1'b0,
    st_keyed   = 1'b1
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: src/key_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "rst_cipher_defines.svh"

module key_checker (
  input  wire rst_cipher_pkg::key_t key,
  output logic                      key_valid
);

  import rst_cipher_pkg::*;

  logic all_alnum;
  logic any_repeat;

  function automatic logic is_alnum(input char_t c);
    logic upper;
    logic lower;
    logic digit;
    upper = (c >= `RST_UPPER_A) && (c <= `RST_UPPER_Z);
    lower = (c >= `RST_LOWER_A) && (c <= `RST_LOWER_Z);
    digit = (c >= `RST_DIGIT_0) && (c <= `RST_DIGIT_9);
    return upper || lower || digit;
  endfunction

  always_comb begin
    all_alnum  = 1'b1;
    any_repeat = 1'b0;
    for (int i = 0; i < `RST_KEY_LEN; i++) begin
      if (!is_alnum(key[i])) begin
        all_alnum = 1'b0;
      end
      // each pair compared once
      for (int j = i + 1; j < `RST_KEY_LEN; j++) begin
        if (key[i] == key[j]) begin
          any_repeat = 1'b1;
        end
      end
    end
  end

  assign key_valid = all_alnum && !any_repeat;

endmodule

`default_nettype wire

// File: src/substitution_lookup.sv
`timescale 1ns/1ns
`default_nettype none

`include "rst_cipher_defines.svh"

module substitution_lookup (
  input  wire rst_cipher_pkg::char_t                     ptxt_char,
  input  wire                                            ctxt_ready,
  input  wire rst_cipher_pkg::char_t [`RST_HALF_LEN-1:0] table_rows,
  input  wire rst_cipher_pkg::char_t [`RST_HALF_LEN-1:0] table_cols,
  output logic                                           char_valid,
  output logic                                           err_invalid_ptxt_char,
  output rst_cipher_pkg::ctxt_t                          ctxt_str
);

  import rst_cipher_pkg::*;

  localparam int SEL_W = $clog2(`RST_HALF_LEN);

  // digits follow the 26 letters
  localparam sym_idx_t DIGIT_BASE = sym_idx_t'(26);

  logic             is_upper;
  logic             is_lower;
  logic             is_digit;
  sym_idx_t         sym_idx;
  logic [SEL_W-1:0] row_sel;
  logic [SEL_W-1:0] col_sel;

  assign is_upper = (ptxt_char >= `RST_UPPER_A) && (ptxt_char <= `RST_UPPER_Z);
  assign is_lower = (ptxt_char >= `RST_LOWER_A) && (ptxt_char <= `RST_LOWER_Z);
  assign is_digit = (ptxt_char >= `RST_DIGIT_0) && (ptxt_char <= `RST_DIGIT_9);

  assign char_valid            = is_upper || is_lower || is_digit;
  assign err_invalid_ptxt_char = !char_valid;

  // case folded symbol index
  always_comb begin
    sym_idx = '0;
    if (is_lower) begin
      sym_idx = sym_idx_t'(ptxt_char - char_t'(`RST_LOWER_A));
    end else if (is_upper) begin
      sym_idx = sym_idx_t'(ptxt_char - char_t'(`RST_UPPER_A));
    end else if (is_digit) begin
      sym_idx = sym_idx_t'(ptxt_char - char_t'(`RST_DIGIT_0)) + DIGIT_BASE;
    end
  end

  // table is six by six
  assign row_sel = SEL_W'(sym_idx / `RST_HALF_LEN);
  assign col_sel = SEL_W'(sym_idx % `RST_HALF_LEN);

  always_comb begin
    if (ctxt_ready) begin
      ctxt_str = {table_rows[row_sel], table_cols[col_sel]};
    end else begin
      ctxt_str = '0;
    end
  end

endmodule

`default_nettype wire

// File: src/cipher_control.sv
`timescale 1ns/1ns
`default_nettype none

module cipher_control (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  ptxt_valid,
  input  wire  key_valid,
  input  wire  char_valid,
  output logic install,
  output logic rotate,
  output logic ctxt_ready,
  output logic err_invalid_key,
  output logic key_not_installed
);

  import rst_cipher_pkg::*;

  ctrl_state_e state_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_unkeyed;
    end else if (install) begin
      // stays keyed until the next reset
      state_q <= st_keyed;
    end
  end

  // key error is registered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_invalid_key <= 1'b0;
    end else begin
      err_invalid_key <= !key_valid;
    end
  end

  // only the first valid key is taken
  assign install = (state_q == st_unkeyed) && key_valid;

  // acceptance of one plaintext character
  assign ctxt_ready = (state_q == st_keyed) && ptxt_valid && char_valid;
  assign rotate     = ctxt_ready;

  assign key_not_installed = (state_q == st_unkeyed);

  // no ciphertext before a key is installed
  a_no_ready_unkeyed: assert property (
    @(posedge clk) disable iff (!rst_n)
    ctxt_ready |-> $past(install) || $past(state_q == st_keyed)
  );

  // install is a single pulse and never returns once keyed
  a_install_once: assert property (
    @(posedge clk) disable iff (!rst_n)
    install |=> !install && (state_q == st_keyed)
  );

endmodule

`default_nettype wire

// File: src/rotor_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "rst_cipher_defines.svh"

module rotor_table (
  input  wire rst_cipher_pkg::key_t                      key,
  input  wire                                            clk,
  input  wire                                            rst_n,
  input  wire                                            install,
  input  wire                                            rotate,
  output rst_cipher_pkg::char_t [`RST_HALF_LEN-1:0]      table_rows,
  output rst_cipher_pkg::char_t [`RST_HALF_LEN-1:0]      table_cols
);

  import rst_cipher_pkg::*;

  char_t [`RST_HALF_LEN-1:0] init_rows;
  char_t [`RST_HALF_LEN-1:0] init_cols;

  // rows from odd key characters, columns from even ones
  always_comb begin
    init_rows[0] = key[11];
    init_rows[1] = key[1];
    init_rows[2] = key[9];
    init_rows[3] = key[3];
    init_rows[4] = key[7];
    init_rows[5] = key[5];
    init_cols[0] = key[10];
    init_cols[1] = key[0];
    init_cols[2] = key[8];
    init_cols[3] = key[2];
    init_cols[4] = key[6];
    init_cols[5] = key[4];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      table_rows <= '0;
      table_cols <= '0;
    end else if (install) begin
      table_rows <= init_rows;
      table_cols <= init_cols;
    end else if (rotate) begin
      // last entry wraps to position 0
      table_rows <= {table_rows[`RST_HALF_LEN-2:0], table_rows[`RST_HALF_LEN-1]};
      table_cols <= {table_cols[`RST_HALF_LEN-2:0], table_cols[`RST_HALF_LEN-1]};
    end
  end

  // load and rotation come from exclusive control states
  a_no_load_and_rotate: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(install && rotate)
  );

endmodule

`default_nettype wire

// File: src/rst_cipher_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rst_cipher_defines.svh"

module rst_cipher_top (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        ptxt_valid,
  input  wire rst_cipher_pkg::key_t  key,
  input  wire rst_cipher_pkg::char_t ptxt_char,
  output wire rst_cipher_pkg::ctxt_t ctxt_str,
  output wire                        ctxt_ready,
  output wire                        err_invalid_ptxt_char,
  output wire                        err_invalid_key,
  output wire                        key_not_installed
);

  import rst_cipher_pkg::*;

  char_t [`RST_HALF_LEN-1:0] table_rows;
  char_t [`RST_HALF_LEN-1:0] table_cols;
  logic                      key_valid;
  logic                      char_valid;
  logic                      install;
  logic                      rotate;

  key_checker u_key_checker (
    .key       (key),
    .key_valid (key_valid)
  );

  cipher_control u_cipher_control (
    .clk               (clk),
    .rst_n             (rst_n),
    .ptxt_valid        (ptxt_valid),
    .key_valid         (key_valid),
    .char_valid        (char_valid),
    .install           (install),
    .rotate            (rotate),
    .ctxt_ready        (ctxt_ready),
    .err_invalid_key   (err_invalid_key),
    .key_not_installed (key_not_installed)
  );

  rotor_table u_rotor_table (
    .key        (key),
    .clk        (clk),
    .rst_n      (rst_n),
    .install    (install),
    .rotate     (rotate),
    .table_rows (table_rows),
    .table_cols (table_cols)
  );

  // ciphertext comes from the table as it stands before rotation
  substitution_lookup u_substitution_lookup (
    .ptxt_char             (ptxt_char),
    .ctxt_ready            (ctxt_ready),
    .table_rows            (table_rows),
    .table_cols            (table_cols),
    .char_valid            (char_valid),
    .err_invalid_ptxt_char (err_invalid_ptxt_char),
    .ctxt_str              (ctxt_str)
  );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n,
  input  wire  reset_req
);

  localparam int HALF_PERIOD_NS = 5;
  localparam int RESET_CYCLES   = 4;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD_NS clk = ~clk;
  end

  // power-on reset, then one more reset per request
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    forever begin
      @(posedge clk);
      if (reset_req) begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "rst_cipher_defines.svh"

module tb_checker (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        ptxt_valid,
  input  wire rst_cipher_pkg::char_t ptxt_char,
  input  wire rst_cipher_pkg::key_t  key,
  input  wire rst_cipher_pkg::ctxt_t ctxt_str,
  input  wire                        ctxt_ready,
  input  wire                        err_invalid_ptxt_char,
  input  wire                        err_invalid_key,
  input  wire                        key_not_installed,
  output int                         error_count,
  output int                         check_count
);

  import rst_cipher_pkg::*;

  char_t [`RST_HALF_LEN-1:0] model_rows;
  char_t [`RST_HALF_LEN-1:0] model_cols;
  logic                      model_keyed;
  logic                      model_err_key;
  int                        rot_slot;

  // pairs seen per symbol and rotation phase since install
  ctxt_t seen_pair  [0:35][0:`RST_HALF_LEN-1];
  logic  seen_valid [0:35][0:`RST_HALF_LEN-1];

  function automatic int symbol_of(input char_t c);
    if (c >= "a" && c <= "z") return c - "a";
    if (c >= "A" && c <= "Z") return c - "A";
    if (c >= "0" && c <= "9") return c - "0" + 26;
    return -1;
  endfunction

  function automatic logic key_ok(input key_t k);
    for (int i = 0; i < `RST_KEY_LEN; i++) begin
      if (symbol_of(k[i]) < 0) return 1'b0;
      for (int j = 0; j < i; j++) begin
        if (k[i] == k[j]) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // reference model of one cycle of the lookup
  function automatic void expected_outputs(
    input  char_t                     c,
    input  logic                      valid,
    input  logic                      keyed,
    input  char_t [`RST_HALF_LEN-1:0] rows,
    input  char_t [`RST_HALF_LEN-1:0] cols,
    output ctxt_t                     exp_str,
    output logic                      exp_ready,
    output logic                      exp_err
  );
    int sym;
    sym       = symbol_of(c);
    exp_err   = (sym < 0);
    exp_ready = keyed && valid && (sym >= 0);
    exp_str   = '0;
    if (exp_ready) begin
      exp_str = {rows[sym / `RST_HALF_LEN], cols[sym % `RST_HALF_LEN]};
    end
  endfunction

  task automatic check_eq(input string what, input logic [15:0] got, input logic [15:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_model(input key_t k);
    // listed from index 5 down to 0
    model_rows = {k[5], k[7], k[3], k[9], k[1], k[11]};
    model_cols = {k[4], k[6], k[2], k[8], k[0], k[10]};
    for (int s = 0; s < 36; s++) begin
      for (int p = 0; p < `RST_HALF_LEN; p++) begin
        seen_valid[s][p] = 1'b0;
      end
    end
  endtask

  task automatic rotate_model();
    char_t [`RST_HALF_LEN-1:0] rows_old;
    char_t [`RST_HALF_LEN-1:0] cols_old;
    rows_old = model_rows;
    cols_old = model_cols;
    // every entry moves up one, the last wraps to 0
    for (int i = 0; i < `RST_HALF_LEN; i++) begin
      model_rows[(i + 1) % `RST_HALF_LEN] = rows_old[i];
      model_cols[(i + 1) % `RST_HALF_LEN] = cols_old[i];
    end
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
  end

  always @(negedge clk) begin : compare
    ctxt_t exp_str;
    logic  exp_ready;
    logic  exp_err;
    int    sym;
    if (!rst_n) begin
      check_eq("err_invalid_key in reset", err_invalid_key, 1'b0);
      check_eq("key_not_installed in reset", key_not_installed, 1'b1);
      check_eq("ctxt_ready in reset", ctxt_ready, 1'b0);
      check_eq("ctxt_str in reset", ctxt_str, 16'h0000);
      model_rows    = '0;
      model_cols    = '0;
      model_keyed   = 1'b0;
      model_err_key = 1'b0;
      rot_slot      = 0;
    end else begin
      expected_outputs(ptxt_char, ptxt_valid, model_keyed, model_rows, model_cols,
                       exp_str, exp_ready, exp_err);
      check_eq("ctxt_ready", ctxt_ready, exp_ready);
      check_eq("ctxt_str", ctxt_str, exp_str);
      check_eq("err_invalid_ptxt_char", err_invalid_ptxt_char, exp_err);
      check_eq("err_invalid_key", err_invalid_key, model_err_key);
      check_eq("key_not_installed", key_not_installed, !model_keyed);
      if (exp_ready) begin
        // same symbol, same phase: upper and lower case must agree
        sym = symbol_of(ptxt_char);
        if (seen_valid[sym][rot_slot]) begin
          check_eq("pair under repeated table state", ctxt_str, seen_pair[sym][rot_slot]);
        end
        seen_pair[sym][rot_slot]  = ctxt_str;
        seen_valid[sym][rot_slot] = 1'b1;
      end
      // state as the next rising edge leaves it
      model_err_key = !key_ok(key);
      if (!model_keyed && key_ok(key)) begin
        load_model(key);
        model_keyed = 1'b1;
        rot_slot    = 0;
      end else if (exp_ready) begin
        rotate_model();
        rot_slot = (rot_slot + 1) % `RST_HALF_LEN;
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top;

  import rst_cipher_pkg::*;

  localparam int CLK_PERIOD_NS = 10;
  localparam int STREAM_LEN    = 160;
  localparam int IGNORED_LEN   = 30;
  localparam int REKEY_LEN     = 100;

  // every driven slot counts, idle ones too
  localparam int CHARS_SENT = 3 + 8 + 7 + 16 + STREAM_LEN + IGNORED_LEN + 2 + REKEY_LEN;
  localparam int WATCHDOG_CYCLES = CHARS_SENT + 50;

  logic        clk;
  logic        rst_n;
  logic        reset_req;
  logic        ptxt_valid;
  char_t       ptxt_char;
  key_t        key;
  ctxt_t       ctxt_str;
  logic        ctxt_ready;
  logic        err_invalid_ptxt_char;
  logic        err_invalid_key;
  logic        key_not_installed;
  int          error_count;
  int          check_count;
  int unsigned seed_draw;

  tb_clock_gen clk_gen0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .reset_req (reset_req)
  );

  rst_cipher_top dut0 (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .ptxt_valid            (ptxt_valid),
    .key                   (key),
    .ptxt_char             (ptxt_char),
    .ctxt_str              (ctxt_str),
    .ctxt_ready            (ctxt_ready),
    .err_invalid_ptxt_char (err_invalid_ptxt_char),
    .err_invalid_key       (err_invalid_key),
    .key_not_installed     (key_not_installed)
  );

  tb_checker chk0 (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .ptxt_valid            (ptxt_valid),
    .ptxt_char             (ptxt_char),
    .key                   (key),
    .ctxt_str              (ctxt_str),
    .ctxt_ready            (ctxt_ready),
    .err_invalid_ptxt_char (err_invalid_ptxt_char),
    .err_invalid_key       (err_invalid_key),
    .key_not_installed     (key_not_installed),
    .error_count           (error_count),
    .check_count           (check_count)
  );

  function automatic key_t make_key(input string s);
    key_t k;
    k = '0;
    for (int i = 0; i < 12; i++) begin
      k[i] = s[i];
    end
    return k;
  endfunction

  function automatic char_t random_alnum();
    int unsigned r;
    r = $urandom % 62;
    if (r < 26) return char_t'("A" + r);
    if (r < 52) return char_t'("a" + r - 26);
    return char_t'("0" + r - 52);
  endfunction

  // neighbours of the three ranges, a space and a high byte
  function automatic char_t bad_char(input int i);
    case (i)
      0:       return 8'h2F;
      1:       return 8'h3A;
      2:       return 8'h40;
      3:       return 8'h5B;
      4:       return 8'h60;
      5:       return 8'h7B;
      6:       return 8'h20;
      default: return 8'h80;
    endcase
  endfunction

  task automatic drive_cycle(input logic valid, input char_t ch);
    ptxt_valid <= valid;
    ptxt_char  <= ch;
    @(posedge clk);
  endtask

  task automatic send_stream(input int slots);
    logic  valid;
    char_t ch;
    for (int i = 0; i < slots; i++) begin
      valid = ($urandom % 4) != 0;
      ch    = random_alnum();
      // now and then an arbitrary byte
      if (($urandom % 16) == 0) begin
        ch = char_t'($urandom);
      end
      drive_cycle(valid, ch);
    end
  endtask

  task automatic request_reset();
    ptxt_valid <= 1'b0;
    reset_req  <= 1'b1;
    @(posedge clk);
    reset_req <= 1'b0;
    wait (rst_n === 1'b0);
    wait (rst_n === 1'b1);
    @(posedge clk);
  endtask

  initial begin
    ptxt_valid = 1'b0;
    ptxt_char  = '0;
    key        = '0;
    reset_req  = 1'b0;
    seed_draw  = $urandom(32'h7edc_6bd0);
    wait (rst_n === 1'b1);
    @(posedge clk);

    // no key yet, nothing may be accepted
    repeat (3) drive_cycle(1'b1, "A");

    key <= make_key("ABCDEFGHIJKA");
    repeat (3) drive_cycle(1'b1, random_alnum());
    key <= make_key("ABCDEF-HIJKL");
    repeat (3) drive_cycle(1'b1, random_alnum());
    key <= make_key("K3yR0tAbCdEf");
    repeat (2) drive_cycle(1'b0, random_alnum());

    // six rotations bring the table back for the lower case form
    drive_cycle(1'b1, "Q");
    repeat (5) drive_cycle(1'b1, random_alnum());
    drive_cycle(1'b1, "q");

    for (int i = 0; i < 8; i++) begin
      drive_cycle(1'b1, bad_char(i));
      drive_cycle(1'b1, random_alnum());
    end

    send_stream(STREAM_LEN);

    // second valid key, must not replace the first
    key <= make_key("Zx9Wv8Ut7Sr6");
    send_stream(IGNORED_LEN);

    // held key installs once reset is over
    request_reset();
    repeat (2) drive_cycle(1'b0, "0");
    send_stream(REKEY_LEN);

    ptxt_valid <= 1'b0;
    // last compare happens on the falling edge before this one
    @(posedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("timeout: stimulus did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/rst_cipher_pkg.sv
src/key_checker.sv
src/substitution_lookup.sv
src/cipher_control.sv
src/rotor_table.sv
src/rst_cipher_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: Bender.yml
package:
  name: rst_cipher

sources:
  - include_dirs:
      - src
    files:
      - src/rst_cipher_pkg.sv
      - src/key_checker.sv
      - src/substitution_lookup.sv
      - src/cipher_control.sv
      - src/rotor_table.sv
      - src/rst_cipher_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_checker.sv
      - verification/tb_top.sv
